// File: design/align_ecc_top.sv
`timescale 1ns/10ps

module align_ecc_top import ecc_pkg::*; import mem_geom_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      write,
  input  addr_t     wr_adr,
  input  data_t     din,
  input  logic      read,
  input  addr_t     rd_adr,
  output data_t     rd_dout,
  output logic      rd_serr,
  output logic      rd_derr,
  output addr_t     rd_padr,
  output logic      mem_write,
  output row_t      mem_wr_adr,
  output row_word_t mem_bw,
  output row_word_t mem_din,
  output logic      mem_read,
  output row_t      mem_rd_adr,
  input  row_word_t mem_rd_dout
);

  lane_t wr_lane;
  row_t  wr_row;
  lane_t rd_lane;
  row_t  rd_row;
  logic  trk_vld;
  lane_t trk_lane;
  row_t  trk_row;

  // Lane count is a power of two, so the split is plain slicing.
  assign wr_lane = wr_adr[LANE_W-1:0];
  assign wr_row  = wr_adr[ADDR_W-1:LANE_W];
  assign rd_lane = rd_adr[LANE_W-1:0];
  assign rd_row  = rd_adr[ADDR_W-1:LANE_W];

  assign mem_write  = write;
  assign mem_wr_adr = wr_row;
  assign mem_read   = read;
  assign mem_rd_adr = rd_row;

  write_packer i_packer (
    .write   (write),
    .lane    (wr_lane),
    .din     (din),
    .bw      (mem_bw),
    .row_din (mem_din)
  );

  read_tracker i_tracker (
    .clk      (clk),
    .arst_n   (arst_n),
    .read     (read),
    .lane     (rd_lane),
    .row      (rd_row),
    .trk_vld  (trk_vld),
    .trk_lane (trk_lane),
    .trk_row  (trk_row)
  );

  read_unpacker i_unpacker (
    .trk_vld     (trk_vld),
    .trk_lane    (trk_lane),
    .trk_row     (trk_row),
    .mem_rd_dout (mem_rd_dout),
    .rd_dout     (rd_dout),
    .rd_serr     (rd_serr),
    .rd_derr     (rd_derr),
    .rd_padr     (rd_padr)
  );

  a_rd_cmd: assert property (@(posedge clk) disable iff (!arst_n) mem_read |-> read)
    else $error("align_ecc_top: mem_read without read");

endmodule

// File: design/ecc_decoder.sv
`timescale 1ns/10ps

module ecc_decoder import ecc_pkg::*; (
  input  code_t code,
  output data_t data,
  output logic  serr,
  output logic  derr
);

  data_t     raw;
  ecc_t      stored;
  ecc_t      recalc;
  syndrome_t synd;
  logic      par;
  data_t     flip;

  assign raw    = code[DATA_W-1:0];
  assign stored = code[CODE_W-1:DATA_W];

  ecc_encoder i_enc (
    .data (raw),
    .ecc  (recalc)
  );

  assign synd = recalc[SYND_W-1:0] ^ stored[SYND_W-1:0];
  assign par  = ^{synd, recalc[ECC_W-1], stored[ECC_W-1]};   // Parity of all 39 bits.

  // A data bit flips when the syndrome equals its Hamming position.
  always_comb begin
    syndrome_t pos;
    for (int i = 0; i < DATA_W; i++) begin
      for (int j = 0; j < SYND_W; j++) begin
        pos[j] = CHECK_MASK[j][i];
      end
      flip[i] = par && (synd == pos);
    end
  end

  assign data = raw ^ flip;

  assign serr = par && (synd < CODE_W);   // Zero syndrome means bit 6 itself.
  assign derr = (synd != '0) && (!par || (synd >= CODE_W));

  always_comb begin
    if (!$isunknown(code)) begin
      assert final (!(serr && derr))
        else $error("ecc_decoder: serr and derr both set");
    end
  end

endmodule

// File: design/ecc_encoder.sv
`timescale 1ns/10ps

module ecc_encoder import ecc_pkg::*; (
  input  data_t data,
  output ecc_t  ecc
);

  syndrome_t chk;

  always_comb begin
    for (int j = 0; j < SYND_W; j++) begin
      chk[j] = ^(data & CHECK_MASK[j]);
    end
  end

  // Overall parity covers the data and the six Hamming checks.
  assign ecc = {^{data, chk}, chk};

endmodule

// File: design/ecc_pkg.sv
package ecc_pkg;

  localparam int DATA_W = 32;
  localparam int ECC_W  = 7;
  localparam int CODE_W = DATA_W + ECC_W;
  localparam int SYND_W = ECC_W - 1;   // Bit 6 is the overall parity.

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ECC_W-1:0]  ecc_t;
  typedef logic [CODE_W-1:0] code_t;   // {ecc, data}.
  typedef logic [SYND_W-1:0] syndrome_t;

  // Data bit i sits at the (i+1)-th non power of two Hamming position,
  // mask j collects the data bits whose position has bit j set.
  localparam data_t CHECK_MASK [SYND_W] = '{
    32'h56aa_ad5b,
    32'h9b33_366d,
    32'he3c3_c78e,
    32'h03fc_07f0,
    32'h03ff_f800,
    32'hfc00_0000
  };

endpackage

// File: design/mem_geom_pkg.sv
package mem_geom_pkg;

  import ecc_pkg::*;

  localparam int NUM_ADDR   = 1024;
  localparam int ADDR_W     = $clog2(NUM_ADDR);
  localparam int NUM_ROWS   = 256;
  localparam int ROW_W      = $clog2(NUM_ROWS);
  localparam int NUM_LANES  = 4;
  localparam int LANE_W     = $clog2(NUM_LANES);
  localparam int SRAM_DELAY = 2;   // Read latency in cycles.

  typedef logic [ADDR_W-1:0] addr_t;   // {row, lane}.
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [LANE_W-1:0] lane_t;

  // Lane k occupies bits k*CODE_W upward.
  typedef logic [NUM_LANES*CODE_W-1:0] row_word_t;

endpackage

// File: design/read_tracker.sv
`timescale 1ns/10ps

module read_tracker import mem_geom_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  read,
  input  lane_t lane,
  input  row_t  row,
  output logic  trk_vld,
  output lane_t trk_lane,
  output row_t  trk_row
);

  logic [SRAM_DELAY-1:0] vld_q;
  lane_t                 lane_q [SRAM_DELAY];
  row_t                  row_q  [SRAM_DELAY];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[SRAM_DELAY-2:0], read};
    end
  end

  // Address stages only move with a valid read behind them.
  always_ff @(posedge clk) begin
    if (read) begin
      lane_q[0] <= lane;
      row_q[0]  <= row;
    end
    for (int k = 1; k < SRAM_DELAY; k++) begin
      if (vld_q[k-1]) begin
        lane_q[k] <= lane_q[k-1];
        row_q[k]  <= row_q[k-1];
      end
    end
  end

  assign trk_vld  = vld_q[SRAM_DELAY-1];
  assign trk_lane = lane_q[SRAM_DELAY-1];
  assign trk_row  = row_q[SRAM_DELAY-1];

  a_vld_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(trk_vld))
    else $error("read_tracker: trk_vld unknown");

endmodule

// File: design/read_unpacker.sv
`timescale 1ns/10ps

module read_unpacker import ecc_pkg::*; import mem_geom_pkg::*; (
  input  logic      trk_vld,
  input  lane_t     trk_lane,
  input  row_t      trk_row,
  input  row_word_t mem_rd_dout,
  output data_t     rd_dout,
  output logic      rd_serr,
  output logic      rd_derr,
  output addr_t     rd_padr
);

  code_t code;
  logic  serr;
  logic  derr;

  assign code = mem_rd_dout[trk_lane*CODE_W +: CODE_W];   // Tracked lane only.

  ecc_decoder i_dec (
    .code (code),
    .data (rd_dout),
    .serr (serr),
    .derr (derr)
  );

  // Flags mean nothing without a read in this cycle.
  assign rd_serr = trk_vld && serr;
  assign rd_derr = trk_vld && derr;

  assign rd_padr = {trk_lane, trk_row};

endmodule

// File: design/write_packer.sv
`timescale 1ns/10ps

module write_packer import ecc_pkg::*; import mem_geom_pkg::*; (
  input  logic      write,
  input  lane_t     lane,
  input  data_t     din,
  output row_word_t bw,
  output row_word_t row_din
);

  ecc_t  ecc;
  code_t code;

  ecc_encoder i_enc (
    .data (din),
    .ecc  (ecc)
  );

  assign code = {ecc, din};

  assign bw      = write ? (row_word_t'({CODE_W{1'b1}}) << (lane * CODE_W)) : '0;
  assign row_din = row_word_t'(code) << (lane * CODE_W);   // Other lanes stay zero.

  always_comb begin
    if (write && !$isunknown(lane)) begin
      assert final ($countones(bw) == CODE_W)
        else $error("write_packer: bw does not cover exactly one lane");
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f sources.f -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q 'All tests passed!' sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: sources.f
design/ecc_pkg.sv
design/mem_geom_pkg.sv
design/ecc_encoder.sv
design/ecc_decoder.sv
design/write_packer.sv
design/read_tracker.sv
design/read_unpacker.sv
design/align_ecc_top.sv
tb/sram_model.sv
tb/read_monitor.sv
tb/tb_top.sv

// File: tb/read_monitor.sv
`timescale 1ns/10ps

module read_monitor import ecc_pkg::*; import mem_geom_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       write,
  input  addr_t      wr_adr,
  input  data_t      din,
  input  logic       read,
  input  addr_t      rd_adr,
  input  data_t      rd_dout,
  input  logic       rd_serr,
  input  logic       rd_derr,
  input  addr_t      rd_padr,
  input  logic       mem_write,
  input  row_t       mem_wr_adr,
  input  row_word_t  mem_bw,
  input  row_word_t  mem_din,
  input  logic       mem_read,
  input  row_t       mem_rd_adr,
  input  logic [1:0] flip_cnt,
  output int         err_cnt,
  output int         chk_cnt,
  output logic       pending
);

  typedef struct packed {
    logic  vld;
    addr_t adr;
    data_t dat;
  } rd_exp_t;

  data_t   ref_mem [NUM_ADDR];
  rd_exp_t pipe [$];

  initial begin
    err_cnt = 0;
    chk_cnt = 0;
    pending = 1'b0;
  end

  // Data bit i sits at the (i+1)-th position that is not a power of two.
  function automatic int hamming_pos(input int i);
    int p;
    int n;
    p = 2;
    n = 0;
    while (n <= i) begin
      p++;
      if ((p & (p - 1)) != 0) n++;
    end
    return p;
  endfunction

  function automatic code_t encode_word(input data_t d);
    ecc_t c;
    int   p;
    c = '0;
    for (int i = 0; i < DATA_W; i++) begin
      p = hamming_pos(i);
      for (int j = 0; j < SYND_W; j++) begin
        if (p[j]) c[j] = c[j] ^ d[i];
      end
    end
    c[ECC_W-1] = ^{d, c[SYND_W-1:0]};
    return {c, d};
  endfunction

  task automatic log_mismatch(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic check_write();
    code_t     code;
    row_word_t bw_exp;
    row_word_t din_exp;
    code = encode_word(din);
    for (int b = 0; b < NUM_LANES * CODE_W; b++) begin
      bw_exp[b]  = (b / CODE_W) == int'(wr_adr[LANE_W-1:0]);
      din_exp[b] = bw_exp[b] && code[b % CODE_W];
    end
    chk_cnt++;
    if (mem_write !== 1'b1 || mem_wr_adr !== wr_adr[ADDR_W-1:LANE_W] ||
        mem_bw !== bw_exp || mem_din !== din_exp) begin
      log_mismatch($sformatf("write %0h: row %0h bw %0h din %0h, expected bw %0h din %0h",
                             wr_adr, mem_wr_adr, mem_bw, mem_din, bw_exp, din_exp));
    end
  endtask

  task automatic check_read_cmd();
    chk_cnt++;
    if (mem_read !== read || (read && mem_rd_adr !== rd_adr[ADDR_W-1:LANE_W])) begin
      log_mismatch($sformatf("read cmd %b adr %0h: mem_read %b mem_rd_adr %0h",
                             read, rd_adr, mem_read, mem_rd_adr));
    end
  endtask

  task automatic check_read(input rd_exp_t e);
    logic exp_serr;
    logic exp_derr;
    logic ok;
    exp_serr = e.vld && (flip_cnt == 2'd1);
    exp_derr = e.vld && (flip_cnt == 2'd2);   // Data is not defined after a double flip.
    ok = (rd_serr === exp_serr) && (rd_derr === exp_derr);
    if (e.vld) begin
      ok = ok && (rd_padr === {e.adr[LANE_W-1:0], e.adr[ADDR_W-1:LANE_W]});
      ok = ok && (exp_derr || rd_dout === e.dat);
    end
    chk_cnt++;
    if (!ok && !e.vld) begin
      log_mismatch($sformatf("serr %b derr %b with no read in flight", rd_serr, rd_derr));
    end else if (!ok) begin
      log_mismatch($sformatf("read %0h flips %0d: dout %0h serr %b derr %b padr %0h, exp %0h",
                             e.adr, flip_cnt, rd_dout, rd_serr, rd_derr, rd_padr, e.dat));
    end
  endtask

  // Sampled mid-cycle, where all inputs and outputs are stable.
  always @(negedge clk) begin
    rd_exp_t ent;
    if (arst_n) begin
      if (write) check_write();
      if (read || mem_read) check_read_cmd();
      ent = '{read, rd_adr, ref_mem[rd_adr]};
      pipe.push_back(ent);
      if (write) ref_mem[wr_adr] = din;   // After the lookup, so reads see old data.
      if (pipe.size() > SRAM_DELAY) check_read(pipe.pop_front());
      pending = 1'b0;
      foreach (pipe[k]) pending = pending | pipe[k].vld;
    end
  end

endmodule

// File: tb/sram_model.sv
`timescale 1ns/10ps

module sram_model import ecc_pkg::*; import mem_geom_pkg::*; (
  input  logic       clk,
  input  logic       mem_write,
  input  row_t       mem_wr_adr,
  input  row_word_t  mem_bw,
  input  row_word_t  mem_din,
  input  logic       mem_read,
  input  row_t       mem_rd_adr,
  output row_word_t  mem_rd_dout,
  input  lane_t      inj_lane,   // Lane of the read now being issued.
  input  logic [1:0] inj_cnt,
  input  logic [5:0] inj_bit0,
  input  logic [5:0] inj_bit1,
  output logic [1:0] flip_cnt    // Flips inside the row now returning.
);

  row_word_t  mem [NUM_ROWS];
  row_word_t  inj_mask;
  row_word_t  rd_q;
  logic       rd_vld_q = 1'b0;
  logic [1:0] cnt_q;

  always_comb begin
    inj_mask = '0;
    if (inj_cnt >= 2'd1) inj_mask[int'(inj_lane) * CODE_W + int'(inj_bit0)] = 1'b1;
    if (inj_cnt == 2'd2) inj_mask[int'(inj_lane) * CODE_W + int'(inj_bit1)] = 1'b1;
  end

  // Read takes the old row when a write hits it in the same cycle.
  always @(posedge clk) begin
    if (mem_write) mem[mem_wr_adr] <= (mem[mem_wr_adr] & ~mem_bw) | (mem_din & mem_bw);
    rd_vld_q <= mem_read;
    if (mem_read) begin
      rd_q  <= mem[mem_rd_adr] ^ inj_mask;
      cnt_q <= inj_cnt;
    end
    mem_rd_dout <= rd_vld_q ? rd_q : '1;   // All ones decodes as a double error.
    flip_cnt    <= rd_vld_q ? cnt_q : 2'd0;
  end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/10ps

module tb_top import ecc_pkg::*; import mem_geom_pkg::*; ();

  logic        clk;
  logic        arst_n;
  logic        write;
  addr_t       wr_adr;
  data_t       din;
  logic        read;
  addr_t       rd_adr;
  data_t       rd_dout;
  logic        rd_serr;
  logic        rd_derr;
  addr_t       rd_padr;
  logic        mem_write;
  row_t        mem_wr_adr;
  row_word_t   mem_bw;
  row_word_t   mem_din;
  logic        mem_read;
  row_t        mem_rd_adr;
  row_word_t   mem_rd_dout;
  logic [1:0]  inj_cnt;
  logic [5:0]  inj_bit0;
  logic [5:0]  inj_bit1;
  logic [1:0]  flip_cnt;
  int          err_cnt;
  int          chk_cnt;
  logic        pending;
  int          last_err;
  int          last_chk;
  int          timeouts;
  logic [31:0] seed = 32'hc9d6_b5f6;

  align_ecc_top i_dut (.*);

  sram_model i_sram (.*, .inj_lane (rd_adr[LANE_W-1:0]));

  read_monitor i_mon (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    return int'((lcg_step() >> 12) % n);   // Low LCG bits have short periods.
  endfunction

  task automatic drive_cycle(input logic wr, input addr_t wa, input logic rd, input addr_t ra,
                             input logic [1:0] inj);
    @(posedge clk);
    #1;
    write    = wr;
    wr_adr   = wa;
    din      = lcg_step();
    read     = rd;
    rd_adr   = ra;
    inj_cnt  = rd ? inj : 2'd0;
    inj_bit0 = 6'(rand_below(CODE_W));
    inj_bit1 = 6'((int'(inj_bit0) + 1 + rand_below(CODE_W - 1)) % CODE_W);
  endtask

  task automatic finish_test(input string name);
    int n;
    drive_cycle(1'b0, '0, 1'b0, '0, 2'd0);
    n = 0;
    while (pending && n < 16) begin
      @(posedge clk);
      n++;
    end
    if (pending) begin
      $display("Timeout in %s: reads still in flight after %0d cycles", name, n);
      timeouts++;
    end
    $display("test %s: %0d checks, %0d errors", name, chk_cnt - last_chk, err_cnt - last_err);
    last_err = err_cnt;
    last_chk = chk_cnt;
  endtask

  initial begin
    row_t  r;
    lane_t l;
    arst_n   = 1'b0;
    write    = 1'b0;
    wr_adr   = '0;
    din      = '0;
    read     = 1'b0;
    rd_adr   = '0;
    inj_cnt  = 2'd0;
    inj_bit0 = 6'd0;
    inj_bit1 = 6'd0;
    last_err = 0;
    last_chk = 0;
    timeouts = 0;
    repeat (3) @(posedge clk);
    #1 arst_n = 1'b1;

    repeat (8) drive_cycle(1'b0, '0, 1'b0, '0, 2'd0);
    finish_test("reset_idle");

    for (int a = 0; a < NUM_ADDR; a++) drive_cycle(1'b1, addr_t'(a), 1'b0, '0, 2'd0);
    finish_test("write_fill");

    repeat (400) begin
      drive_cycle(rand_below(4) == 0, addr_t'(rand_below(NUM_ADDR)), 1'b1,
                  addr_t'(rand_below(NUM_ADDR)), 2'd0);
    end
    finish_test("clean_reads");

    // Fill the three neighbour lanes, then read the lane back.
    repeat (64) begin
      r = row_t'(rand_below(NUM_ROWS));
      l = lane_t'(rand_below(NUM_LANES));
      for (int k = 1; k < NUM_LANES; k++) drive_cycle(1'b1, {r, lane_t'(l + k)}, 1'b0, '0, 2'd0);
      drive_cycle(1'b0, '0, 1'b1, {r, l}, 2'd0);
    end
    finish_test("lane_isolation");

    repeat (300) drive_cycle(1'b0, '0, 1'b1, addr_t'(rand_below(NUM_ADDR)), 2'd1);
    finish_test("single_flip");

    repeat (300) drive_cycle(1'b0, '0, 1'b1, addr_t'(rand_below(NUM_ADDR)), 2'd2);
    finish_test("double_flip");

    $display("Totals: %0d checks, %0d errors, %0d timeouts", chk_cnt, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
